// File: uart_pkg.sv
// Fixed 8N1 framing with 8 ticks per bit and no parity or flow control
package uart_pkg;

    // One data byte on the serial line and on the command path
    typedef logic [7:0] uart_byte_t;

    // Oversample ticks per bit
    localparam int OVERSAMPLE = 8;

    // Frame layout is start, eight data bits, stop
    localparam int DATA_BITS  = $bits(uart_byte_t);
    localparam int FRAME_BITS = DATA_BITS + 2;

    // Tick position within one bit
    typedef logic [$clog2(OVERSAMPLE)-1:0] tick_cnt_t;

    // Bit position within one frame
    typedef logic [$clog2(FRAME_BITS)-1:0] bit_cnt_t;

endpackage

// File: stat_pkg.sv
// Counter bank size follows the index width and counters wrap silently at 2^32
package stat_pkg;

    // Counter index
    typedef logic [3:0] stat_id_t;

    // Number of counters in the bank
    localparam int STAT_COUNT = 2 ** $bits(stat_id_t);

    // Increment amount, same width as the stats increment bus
    typedef logic [15:0] stat_inc_t;

    // Counter value, modulo 2^32
    typedef logic [31:0] stat_count_t;

    // Bytes per counter reply
    localparam int STAT_BYTES = $bits(stat_count_t) / 8;

    // Reply to a command byte that names no counter
    localparam logic [7:0] STAT_ERR_BYTE = 8'hEE;

endpackage

// File: baud_timer.sv
// PRESCALE must be at least 1 and the first tick comes PRESCALE cycles after reset
`timescale 1ns/1ns

module baud_timer #(
    parameter int PRESCALE = 136
) (
    input  logic clk_125mhz,
    input  logic rst_n_i,
    output logic tick_o
);

    localparam int CNT_W = $clog2(PRESCALE + 1);

    logic [CNT_W-1:0] cnt_q;

    // Free-running down-counter, one tick per reload
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n_i) begin
            cnt_q  <= CNT_W'(PRESCALE - 1);
            tick_o <= 1'b0;
        end else if (cnt_q == '0) begin
            cnt_q  <= CNT_W'(PRESCALE - 1);
            tick_o <= 1'b1;
        end else begin
            cnt_q  <= cnt_q - 1'b1;
            tick_o <= 1'b0;
        end
    end

endmodule

// File: uart_rx.sv
// 8N1 receiver on the shared oversample tick, a byte with a low stop bit is dropped without notice
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
    input  logic       clk_125mhz,
    input  logic       rst_n_i,
    input  logic       tick_i,
    input  logic       uart_rxd_i,
    output uart_byte_t rx_data_o,
    output logic       rx_valid_o
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    localparam tick_cnt_t HALF_BIT = tick_cnt_t'(OVERSAMPLE / 2 - 1);
    localparam tick_cnt_t FULL_BIT = tick_cnt_t'(OVERSAMPLE - 1);

    rx_state_t  state_q;
    logic [1:0] sync_q;
    tick_cnt_t  tick_cnt_q;
    bit_cnt_t   bit_cnt_q;
    uart_byte_t shift_q;
    logic       rxd;

    assign rxd       = sync_q[1];
    assign rx_data_o = shift_q;

    // Line idles high, so the synchronizer resets high
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n_i) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], uart_rxd_i};
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n_i) begin
            state_q    <= RX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (tick_i) begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
                case (state_q)
                    RX_IDLE: begin
                        tick_cnt_q <= '0;
                        if (!rxd) begin
                            state_q <= RX_START;
                        end
                    end
                    RX_START: begin
                        // Middle of start bit, a glitch returns to idle
                        if (tick_cnt_q == HALF_BIT) begin
                            tick_cnt_q <= '0;
                            bit_cnt_q  <= '0;
                            state_q    <= rxd ? RX_IDLE : RX_DATA;
                        end
                    end
                    RX_DATA: begin
                        if (tick_cnt_q == FULL_BIT) begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            if (bit_cnt_q == bit_cnt_t'(DATA_BITS - 1)) begin
                                state_q <= RX_STOP;
                            end
                        end
                    end
                    default: begin
                        if (tick_cnt_q == FULL_BIT) begin
                            rx_valid_o <= rxd;
                            state_q    <= RX_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // LSB first
    always_ff @(posedge clk_125mhz) begin
        if (tick_i && state_q == RX_DATA && tick_cnt_q == FULL_BIT) begin
            shift_q <= {rxd, shift_q[DATA_BITS-1:1]};
        end
    end

endmodule

// File: uart_tx.sv
// 8N1 transmitter, a start request while a frame is in flight is ignored
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
    input  logic       clk_125mhz,
    input  logic       rst_n_i,
    input  logic       tick_i,
    input  logic       tx_start_i,
    input  uart_byte_t tx_data_i,
    output logic       uart_txd_o,
    output logic       tx_done_o
);

    localparam tick_cnt_t FULL_BIT = tick_cnt_t'(OVERSAMPLE - 1);

    logic               busy_q;
    tick_cnt_t          tick_cnt_q;
    bit_cnt_t           bit_cnt_q;
    logic [DATA_BITS:0] shift_q;
    logic               bit_end;

    assign bit_end = busy_q && tick_i && tick_cnt_q == FULL_BIT;

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            uart_txd_o <= 1'b1;
            tx_done_o  <= 1'b0;
        end else begin
            tx_done_o <= 1'b0;
            if (!busy_q) begin
                if (tx_start_i) begin
                    // Start bit goes out at once
                    busy_q     <= 1'b1;
                    tick_cnt_q <= '0;
                    bit_cnt_q  <= '0;
                    uart_txd_o <= 1'b0;
                end
            end else if (tick_i) begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
                if (bit_end) begin
                    if (bit_cnt_q == bit_cnt_t'(FRAME_BITS - 1)) begin
                        busy_q    <= 1'b0;
                        tx_done_o <= 1'b1;
                    end else begin
                        uart_txd_o <= shift_q[0];
                        bit_cnt_q  <= bit_cnt_q + 1'b1;
                    end
                end
            end
        end
    end

    // Data LSB first, stop bit on top
    always_ff @(posedge clk_125mhz) begin
        if (!busy_q && tx_start_i) begin
            shift_q <= {1'b1, tx_data_i};
        end else if (bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: stat_counter_ram.sv
// Increments during the reset sweep are dropped and a read sees an increment from two cycles after its strobe
`timescale 1ns/1ns

module stat_counter_ram import stat_pkg::*; (
    input  logic        clk_125mhz,
    input  logic        rst_n_i,
    input  logic        stat_valid_i,
    input  stat_id_t    stat_id_i,
    input  stat_inc_t   stat_inc_i,
    input  logic        rd_en_i,
    input  stat_id_t    rd_id_i,
    output stat_count_t rd_data_o
);

    stat_count_t mem [STAT_COUNT];

    logic        clr_active_q;
    stat_id_t    clr_idx_q;

    // Stage one holds the increment and the old value
    logic        s1_valid_q;
    stat_id_t    s1_id_q;
    stat_inc_t   s1_inc_q;
    stat_count_t s1_old_q;

    // Stage two holds the last written sum
    logic        s2_valid_q;
    stat_id_t    s2_id_q;
    stat_count_t s2_sum_q;

    stat_count_t s1_base;
    stat_count_t s1_sum;

    // Old value was read before the previous write landed
    assign s1_base = (s2_valid_q && s2_id_q == s1_id_q) ? s2_sum_q : s1_old_q;
    assign s1_sum  = s1_base + stat_count_t'(s1_inc_q);

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n_i) begin
            clr_active_q <= 1'b1;
            clr_idx_q    <= '0;
            s1_valid_q   <= 1'b0;
            s2_valid_q   <= 1'b0;
        end else begin
            if (clr_active_q) begin
                clr_idx_q <= clr_idx_q + 1'b1;
                if (clr_idx_q == stat_id_t'(STAT_COUNT - 1)) begin
                    clr_active_q <= 1'b0;
                end
            end
            s1_valid_q <= stat_valid_i && !clr_active_q;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        s1_id_q  <= stat_id_i;
        s1_inc_q <= stat_inc_i;
        s1_old_q <= mem[stat_id_i];
        s2_id_q  <= s1_id_q;
        s2_sum_q <= s1_sum;
    end

    // Single write port shared by the sweep and the commit
    always_ff @(posedge clk_125mhz) begin
        if (clr_active_q) begin
            mem[clr_idx_q] <= '0;
        end else if (s1_valid_q) begin
            mem[s1_id_q] <= s1_sum;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_id_i];
        end
    end

endmodule

// File: stat_cmd_fsm.sv
// Bytes arriving while a reply is in progress are dropped, so the host must wait for the full reply
`timescale 1ns/1ns

module stat_cmd_fsm import uart_pkg::*, stat_pkg::*; (
    input  logic        clk_125mhz,
    input  logic        rst_n_i,
    input  logic        rx_valid_i,
    input  uart_byte_t  rx_data_i,
    input  stat_count_t rd_data_i,
    input  logic        tx_done_i,
    output logic        rd_en_o,
    output stat_id_t    rd_id_o,
    output logic        tx_start_o,
    output uart_byte_t  tx_data_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_LOAD,
        ST_SEND,
        ST_WAIT
    } state_t;

    localparam int CNT_W = $clog2(STAT_BYTES + 1);
    localparam int MSB   = $bits(stat_count_t) - 1;

    state_t             state_q;
    logic [CNT_W-1:0]   byte_cnt_q;
    stat_count_t        reply_q;

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            byte_cnt_q <= '0;
            rd_en_o    <= 1'b0;
            tx_start_o <= 1'b0;
        end else begin
            rd_en_o    <= 1'b0;
            tx_start_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (rx_valid_i) begin
                        if (rx_data_i < uart_byte_t'(STAT_COUNT)) begin
                            rd_en_o <= 1'b1;
                            rd_id_o <= stat_id_t'(rx_data_i);
                            state_q <= ST_READ;
                        end else begin
                            // Unknown command, one error byte
                            tx_start_o <= 1'b1;
                            tx_data_o  <= STAT_ERR_BYTE;
                            state_q    <= ST_WAIT;
                        end
                    end
                end
                ST_READ: begin
                    state_q <= ST_LOAD;
                end
                ST_LOAD: begin
                    // Top byte leaves now, the rest waits in reply_q
                    tx_start_o <= 1'b1;
                    tx_data_o  <= rd_data_i[MSB -: DATA_BITS];
                    reply_q    <= rd_data_i << DATA_BITS;
                    byte_cnt_q <= CNT_W'(STAT_BYTES - 1);
                    state_q    <= ST_SEND;
                end
                ST_SEND: begin
                    if (tx_done_i) begin
                        tx_start_o <= 1'b1;
                        tx_data_o  <= reply_q[MSB -: DATA_BITS];
                        reply_q    <= reply_q << DATA_BITS;
                        byte_cnt_q <= byte_cnt_q - 1'b1;
                        if (byte_cnt_q == CNT_W'(1)) begin
                            state_q <= ST_WAIT;
                        end
                    end
                end
                default: begin
                    // Last byte in flight
                    if (tx_done_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: fpga_core.sv
// Single clock on clk_125mhz and the stats increment input has no back-pressure
`timescale 1ns/1ns

module fpga_core import uart_pkg::*, stat_pkg::*; #(
    // Clock cycles per oversample tick, 115200 baud by default
    parameter int PRESCALE = (125000000 + 115200 * 4) / (115200 * 8)
) (
    input  logic        clk_125mhz,
    input  logic        rst_n_i,
    input  logic [7:0]  sw_i,
    input  logic        uart_rxd_i,
    input  logic        stat_valid_i,
    input  stat_id_t    stat_id_i,
    input  stat_inc_t   stat_inc_i,
    output logic [7:0]  led_o,
    output logic        uart_txd_o
);

    logic        tick;
    uart_byte_t  rx_data;
    logic        rx_valid;
    uart_byte_t  tx_data;
    logic        tx_start;
    logic        tx_done;
    logic        rd_en;
    stat_id_t    rd_id;
    stat_count_t rd_data;

    assign led_o = sw_i;

    baud_timer #(
        .PRESCALE(PRESCALE)
    ) baud_timer_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n_i(rst_n_i),
        .tick_o(tick)
    );

    uart_rx uart_rx_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n_i(rst_n_i),
        .tick_i(tick),
        .uart_rxd_i(uart_rxd_i),
        .rx_data_o(rx_data),
        .rx_valid_o(rx_valid)
    );

    uart_tx uart_tx_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n_i(rst_n_i),
        .tick_i(tick),
        .tx_start_i(tx_start),
        .tx_data_i(tx_data),
        .uart_txd_o(uart_txd_o),
        .tx_done_o(tx_done)
    );

    // Counter bank fed by the external increment strobe
    stat_counter_ram stat_counter_ram_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n_i(rst_n_i),
        .stat_valid_i(stat_valid_i),
        .stat_id_i(stat_id_i),
        .stat_inc_i(stat_inc_i),
        .rd_en_i(rd_en),
        .rd_id_i(rd_id),
        .rd_data_o(rd_data)
    );

    stat_cmd_fsm stat_cmd_fsm_inst (
        .clk_125mhz(clk_125mhz),
        .rst_n_i(rst_n_i),
        .rx_valid_i(rx_valid),
        .rx_data_i(rx_data),
        .rd_data_i(rd_data),
        .tx_done_i(tx_done),
        .rd_en_o(rd_en),
        .rd_id_o(rd_id),
        .tx_start_o(tx_start),
        .tx_data_o(tx_data)
    );

endmodule

// File: tb_clock.sv
// Free-running testbench clock that starts low, with no reset and no stop control
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// File: tb_fpga_core.sv
// Runs the core at PRESCALE 2 (16 clocks per bit) and the long wrap test takes about 66k cycles
`timescale 1ns/1ns

module tb_fpga_core;

    localparam int BIT_CLKS    = 16;
    localparam int FRAME_CLKS  = 10 * BIT_CLKS;
    localparam int RAND_CYCLES = 300;
    localparam int FWD_CYCLES  = 40;
    localparam int WRAP_CYCLES = 65540;
    localparam int N_CMDS      = 45;
    localparam int INC_CLKS    = RAND_CYCLES + FWD_CYCLES + WRAP_CYCLES + 500;
    localparam int TIMEOUT_CLKS = 2 * (N_CMDS * 5 * FRAME_CLKS + INC_CLKS);
    localparam logic [7:0] ERR_REPLY = 8'hEE;

    logic        clk_125mhz;
    logic        rst_n_i;
    logic [7:0]  sw_i;
    logic        uart_rxd_i;
    logic        stat_valid_i;
    logic [3:0]  stat_id_i;
    logic [15:0] stat_inc_i;
    logic [7:0]  led_o;
    logic        uart_txd_o;

    // Reference counter bank, wraps like the hardware
    logic [31:0] model [16];

    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    tb_clock #(.PERIOD_NS(20)) clk_gen (.clk_o(clk_125mhz));

    fpga_core #(
        .PRESCALE(2)
    ) DUT (
        .clk_125mhz(clk_125mhz),
        .rst_n_i(rst_n_i),
        .sw_i(sw_i),
        .uart_rxd_i(uart_rxd_i),
        .stat_valid_i(stat_valid_i),
        .stat_id_i(stat_id_i),
        .stat_inc_i(stat_inc_i),
        .led_o(led_o),
        .uart_txd_o(uart_txd_o)
    );

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("Test %s done, no errors", name);
        end else begin
            tests_failed++;
            $display("Test %s done, %0d errors", name, errors - errs_before);
        end
    endtask

    // One increment strobe, the model follows the same amount
    task automatic apply_inc(input logic valid, input logic [3:0] id, input logic [15:0] amt);
        @(posedge clk_125mhz);
        stat_valid_i <= valid;
        stat_id_i    <= id;
        stat_inc_i   <= amt;
        if (valid) begin
            model[id] = model[id] + 32'(amt);
        end
    endtask

    task automatic idle_inc(input int cycles);
        repeat (cycles) begin
            @(posedge clk_125mhz);
            stat_valid_i <= 1'b0;
        end
    endtask

    // Stop bit simply runs into the idle level
    task automatic send_byte(input logic [7:0] data);
        int i;
        @(posedge clk_125mhz);
        uart_rxd_i <= 1'b0;
        repeat (BIT_CLKS) @(posedge clk_125mhz);
        for (i = 0; i < 8; i++) begin
            uart_rxd_i <= data[i];
            repeat (BIT_CLKS) @(posedge clk_125mhz);
        end
        uart_rxd_i <= 1'b1;
    endtask

    // Samples the middle of each bit after the start edge
    task automatic recv_byte(output logic [7:0] data);
        int i;
        @(negedge uart_txd_o);
        repeat (BIT_CLKS / 2) @(posedge clk_125mhz);
        check_equal(32'(uart_txd_o), 32'd0, "reply start bit");
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(posedge clk_125mhz);
            data[i] = uart_txd_o;
        end
        repeat (BIT_CLKS) @(posedge clk_125mhz);
        check_equal(32'(uart_txd_o), 32'd1, "reply stop bit");
    endtask

    // Reply arrives MSB first
    task automatic query_counter(input logic [3:0] id, output logic [31:0] value);
        logic [7:0] b;
        int k;
        value = '0;
        send_byte({4'h0, id});
        for (k = 0; k < 4; k++) begin
            recv_byte(b);
            value = {value[23:0], b};
        end
    endtask

    task automatic read_and_compare(input logic [3:0] id);
        logic [31:0] value;
        query_counter(id, value);
        check_equal(value, model[id], $sformatf("counter %0d", id));
    endtask

    initial begin
        repeat (TIMEOUT_CLKS) @(posedge clk_125mhz);
        $display("Run timed out after %0d clock cycles without finishing", TIMEOUT_CLKS);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int i;
        int mark;
        int lows;
        logic [7:0]  v;
        logic [3:0]  idx;
        logic [7:0]  b;
        logic [31:0] value;

        rst_n_i      = 1'b0;
        sw_i         = '0;
        uart_rxd_i   = 1'b1;
        stat_valid_i = 1'b0;
        stat_id_i    = '0;
        stat_inc_i   = '0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (i = 0; i < 16; i++) begin
            model[i] = '0;
        end
        void'($urandom(95));

        repeat (3) @(posedge clk_125mhz);
        rst_n_i <= 1'b1;
        // Counter clear sweep must finish first
        repeat (20) @(posedge clk_125mhz);

        mark = errors;
        for (i = 0; i < 50; i++) begin
            v = 8'($urandom);
            @(posedge clk_125mhz);
            sw_i <= v;
            @(posedge clk_125mhz);
            check_equal(32'(led_o), 32'(v), "led mirror");
        end
        finish_test("leds", mark);

        mark = errors;
        lows = 0;
        repeat (200) begin
            @(posedge clk_125mhz);
            if (!uart_txd_o) lows++;
        end
        check_equal(32'(lows), 32'd0, "idle line low cycles");
        for (i = 0; i < 16; i++) begin
            read_and_compare(4'(i));
        end
        finish_test("idle and zero", mark);

        mark = errors;
        for (i = 0; i < RAND_CYCLES; i++) begin
            apply_inc(1'($urandom % 2), 4'($urandom % 16), 16'($urandom));
        end
        idle_inc(4);
        for (i = 0; i < 16; i++) begin
            read_and_compare(4'(i));
        end
        finish_test("random increments", mark);

        // Same index every cycle goes through the forwarding path
        mark = errors;
        idx = 4'($urandom % 16);
        for (i = 0; i < FWD_CYCLES; i++) begin
            apply_inc(1'b1, idx, 16'($urandom));
        end
        idle_inc(4);
        read_and_compare(idx);
        finish_test("forwarding", mark);

        mark = errors;
        idx = 4'($urandom % 16);
        for (i = 0; i < WRAP_CYCLES; i++) begin
            apply_inc(1'b1, idx, 16'hFFFF);
        end
        for (i = 0; i < 8; i++) begin
            apply_inc(1'b1, idx, 16'hFF00 | 16'($urandom % 256));
        end
        idle_inc(4);
        read_and_compare(idx);
        finish_test("wrap", mark);

        mark = errors;
        for (i = 0; i < 10; i++) begin
            v = 8'(16 + $urandom % 240);
            send_byte(v);
            recv_byte(b);
            check_equal(32'(b), 32'(ERR_REPLY), $sformatf("reply to command %0h", v));
            // Nothing more may follow the error byte
            lows = 0;
            repeat (2 * FRAME_CLKS) begin
                @(posedge clk_125mhz);
                if (!uart_txd_o) lows++;
            end
            check_equal(32'(lows), 32'd0, "extra reply after error byte");
        end
        idx = 4'($urandom % 16);
        query_counter(idx, value);
        check_equal(value, model[idx], "counter after bad commands");
        finish_test("bad commands", mark);

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: list.f
uart_pkg.sv
stat_pkg.sv
baud_timer.sv
uart_rx.sv
uart_tx.sv
stat_counter_ram.sv
stat_cmd_fsm.sv
fpga_core.sv
tb_clock.sv
tb_fpga_core.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := tb_fpga_core
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
